// ==== hw/ic_data_array.sv ====
// Instruction cache data array
// Four ways of four 34-bit subbanks, fill and debug writes, way-select read
`timescale 1ns/1ps

module ic_data_array (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [31:4]               ic_rw_addr,
   input  logic                      ic_rd_en,
   input  ic_mem_pkg::ic_way_mask_t  ic_wr_en,
   input  ic_mem_pkg::ic_row_t       ic_wr_data,
   input  ic_mem_pkg::ic_debug_req_t ic_debug,
   input  ic_mem_pkg::ic_way_mask_t  ic_rd_hit,
   output ic_mem_pkg::ic_row_t       ic_rd_data
);

   import ic_mem_pkg::*;

   logic                       dbg_data_wr;
   logic [NUM_SUBBANKS-1:0]    dbg_sb_sel;       // Decoded debug addr[3:2]
   ic_way_mask_t               dbg_rd_way;
   ic_way_mask_t               dbg_wr_way;
   ic_way_mask_t               dbg_rd_way_ff;
   logic                       dbg_rd_en_ff;
   ic_way_mask_t               sb_re;
   ic_way_mask_t               rd_sel;
   ic_subbank_t                sb_wr_data [NUM_SUBBANKS];
   ic_subbank_t                sb_q [NUM_WAYS][NUM_SUBBANKS];
   logic [ICACHE_TAG_HIGH-1:4] data_idx;

   ////////////////////////////////////////////////////////////
   // Debug decode and write steering
   ////////////////////////////////////////////////////////////
   assign dbg_data_wr = ic_debug.wr_en & ~ic_debug.tag_array;
   assign dbg_sb_sel  = NUM_SUBBANKS'(1) << ic_debug.addr[3:2];

   assign dbg_rd_way = {NUM_WAYS{ic_debug.rd_en & ~ic_debug.tag_array}} & ic_debug.way;
   assign dbg_wr_way = {NUM_WAYS{dbg_data_wr}} & ic_debug.way;

   assign sb_re = {NUM_WAYS{ic_rd_en}} | dbg_rd_way;

   // Debug word lands in one subbank, fill data in all four
   always_comb begin
      for (int k = 0; k < NUM_SUBBANKS; k++) begin
         if (dbg_data_wr && dbg_sb_sel[k]) begin
            sb_wr_data[k] = ic_debug.wr_data;
         end else begin
            sb_wr_data[k] = ic_wr_data[k];
         end
      end
   end

   assign data_idx = (ic_debug.rd_en | ic_debug.wr_en) ?
                     ic_debug.addr[ICACHE_TAG_HIGH-1:4] :
                     ic_rw_addr[ICACHE_TAG_HIGH-1:4];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dbg_rd_en_ff  <= 1'b0;
         dbg_rd_way_ff <= '0;
      end else begin
         dbg_rd_en_ff  <= ic_debug.rd_en;
         dbg_rd_way_ff <= dbg_rd_way;
      end
   end

   ////////////////////////////////////////////////////////////
   // Data ways
   ////////////////////////////////////////////////////////////
   for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
      for (genvar k = 0; k < NUM_SUBBANKS; k++) begin : g_sb
         logic sb_we;

         assign sb_we = ic_wr_en[i] | (dbg_wr_way[i] & dbg_sb_sel[k]);

         ic_sram #(
            .entry_t (ic_subbank_t),
            .DEPTH   (DATA_DEPTH)
         ) i_data_sram (
            .clk  (clk),
            .we   (sb_we),
            .re   (sb_re[i]),
            .addr (data_idx),
            .d    (sb_wr_data[k]),
            .q    (sb_q[i][k])
         );
      end
   end

   // Debug read overrides the tag hits for one cycle
   assign rd_sel = dbg_rd_en_ff ? dbg_rd_way_ff : ic_rd_hit;

   always_comb begin
      ic_rd_data = '0;
      for (int i = 0; i < NUM_WAYS; i++) begin
         for (int k = 0; k < NUM_SUBBANKS; k++) begin
            if (rd_sel[i]) begin
               ic_rd_data[k] = ic_rd_data[k] | sb_q[i][k];
            end
         end
      end
   end

endmodule

// ==== hw/ic_mem.sv ====
// Instruction cache memory top
// Joins the tag array and the data array
`timescale 1ns/1ps

module ic_mem (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [31:4]               ic_rw_addr,
   input  logic                      ic_rd_en,
   input  ic_mem_pkg::ic_way_mask_t  ic_wr_en,       // Fill ways
   input  ic_mem_pkg::ic_row_t       ic_wr_data,
   input  ic_mem_pkg::ic_way_mask_t  ic_tag_valid,   // Sampled with the hit
   input  ic_mem_pkg::ic_debug_req_t ic_debug,
   output ic_mem_pkg::ic_way_mask_t  ic_rd_hit,
   output logic                      ic_tag_perr,
   output ic_mem_pkg::ic_row_t       ic_rd_data,
   output ic_mem_pkg::ic_tag_entry_t ictag_debug_rd_data
);

   ////////////////////////////////////////////////////////////
   // Tag side
   ////////////////////////////////////////////////////////////
   ic_tag_array i_ic_tag_array (
      .clk                 (clk),
      .rst_n               (rst_n),
      .ic_rw_addr          (ic_rw_addr),
      .ic_rd_en            (ic_rd_en),
      .ic_wr_en            (ic_wr_en),
      .ic_tag_valid        (ic_tag_valid),
      .ic_debug            (ic_debug),
      .ic_rd_hit           (ic_rd_hit),
      .ic_tag_perr         (ic_tag_perr),
      .ictag_debug_rd_data (ictag_debug_rd_data)
   );

   ////////////////////////////////////////////////////////////
   // Data side with the way select from the tag hits
   ////////////////////////////////////////////////////////////
   ic_data_array i_ic_data_array (
      .clk        (clk),
      .rst_n      (rst_n),
      .ic_rw_addr (ic_rw_addr),
      .ic_rd_en   (ic_rd_en),
      .ic_wr_en   (ic_wr_en),
      .ic_wr_data (ic_wr_data),
      .ic_debug   (ic_debug),
      .ic_rd_hit  (ic_rd_hit),
      .ic_rd_data (ic_rd_data)
   );

endmodule

// ==== hw/ic_mem_pkg.sv ====
// Instruction cache memory package
// Geometry of the parity build and the packed types shared by the arrays
package ic_mem_pkg;

   ////////////////////////////////////////////////////////////
   // Geometry
   ////////////////////////////////////////////////////////////
   localparam int NUM_WAYS        = 4;     // Ways per set
   localparam int NUM_SUBBANKS    = 4;     // 32-bit subbanks per row
   localparam int ICACHE_TAG_HIGH = 12;    // Lowest tag address bit
   localparam int ICACHE_TAG_LOW  = 6;     // Lowest tag index bit
   localparam int TAG_W           = 20;    // Bits [31:12]
   localparam int TAG_DEPTH       = 64;    // One entry per 64B line
   localparam int DATA_DEPTH      = 256;   // One entry per 16B row
   localparam int SB_DATA_W       = 32;
   localparam int SB_PAR_W        = 2;     // One parity bit per halfword

   ////////////////////////////////////////////////////////////
   // Types
   ////////////////////////////////////////////////////////////
   typedef logic [NUM_WAYS-1:0] ic_way_mask_t;   // One bit per way

   typedef struct packed {
      logic             parity;    // Even parity over tag
      logic [TAG_W-1:0] tag;
   } ic_tag_entry_t;

   typedef struct packed {
      logic [SB_PAR_W-1:0]  par;   // Stored as filled, not checked here
      logic [SB_DATA_W-1:0] data;
   } ic_subbank_t;

   // Subbank 0 sits in the low bits
   typedef ic_subbank_t [NUM_SUBBANKS-1:0] ic_row_t;

   typedef struct packed {
      logic                            rd_en;
      logic                            wr_en;
      logic                            tag_array;   // 1 tags, 0 data
      ic_way_mask_t                    way;
      logic [ICACHE_TAG_HIGH-1:2]      addr;        // Address bits [11:2]
      logic [SB_PAR_W+SB_DATA_W-1:0]   wr_data;     // Tag write uses [32] and [31:12]
   } ic_debug_req_t;

endpackage

// ==== hw/ic_sram.sv ====
// Behavioral single-port SRAM
// Synchronous write, one-cycle read, output holds between reads
`timescale 1ns/1ps

module ic_sram #(
   parameter type entry_t = logic,
   parameter int  DEPTH   = 64
) (
   input  logic                     clk,
   input  logic                     we,
   input  logic                     re,
   input  logic [$clog2(DEPTH)-1:0] addr,
   input  entry_t                   d,
   output entry_t                   q
);

   entry_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= d;          // Write wins over read
      end else if (re) begin
         q <= mem[addr];
      end
   end

endmodule

// ==== hw/ic_tag_array.sv ====
// Instruction cache tag array
// Four tag ways with even parity, hit compare and debug tag access
`timescale 1ns/1ps

module ic_tag_array (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [31:4]               ic_rw_addr,
   input  logic                      ic_rd_en,
   input  ic_mem_pkg::ic_way_mask_t  ic_wr_en,
   input  ic_mem_pkg::ic_way_mask_t  ic_tag_valid,
   input  ic_mem_pkg::ic_debug_req_t ic_debug,
   output ic_mem_pkg::ic_way_mask_t  ic_rd_hit,
   output logic                      ic_tag_perr,
   output ic_mem_pkg::ic_tag_entry_t ictag_debug_rd_data
);

   import ic_mem_pkg::*;

   ic_way_mask_t  dbg_rd_way;        // Debug tag read, per way
   ic_way_mask_t  dbg_wr_way;        // Debug tag write, per way
   ic_way_mask_t  dbg_rd_way_ff;
   ic_way_mask_t  tag_we;
   ic_way_mask_t  tag_re;
   ic_way_mask_t  way_perr;
   logic          fill_tag_par;
   ic_tag_entry_t tag_wr_data;
   ic_tag_entry_t tag_q [NUM_WAYS];

   logic [31:ICACHE_TAG_HIGH]               fetch_tag_ff;
   logic [ICACHE_TAG_HIGH-1:ICACHE_TAG_LOW] tag_idx;

   ////////////////////////////////////////////////////////////
   // Write and read enables
   ////////////////////////////////////////////////////////////
   assign dbg_rd_way = {NUM_WAYS{ic_debug.rd_en & ic_debug.tag_array}} & ic_debug.way;
   assign dbg_wr_way = {NUM_WAYS{ic_debug.wr_en & ic_debug.tag_array}} & ic_debug.way;

   // A line's tag goes in with its last row, so a partial fill never hits
   assign tag_we = (ic_wr_en & {NUM_WAYS{ic_rw_addr[5:4] == 2'b11}}) | dbg_wr_way;
   assign tag_re = {NUM_WAYS{ic_rd_en}} | dbg_rd_way;

   assign fill_tag_par = ^ic_rw_addr[31:ICACHE_TAG_HIGH];   // Even parity

   assign tag_wr_data = (ic_debug.wr_en & ic_debug.tag_array) ?
                        {ic_debug.wr_data[32], ic_debug.wr_data[31:ICACHE_TAG_HIGH]} :
                        {fill_tag_par, ic_rw_addr[31:ICACHE_TAG_HIGH]};

   // Debug owns the index while either strobe is up
   assign tag_idx = (ic_debug.rd_en | ic_debug.wr_en) ?
                    ic_debug.addr[ICACHE_TAG_HIGH-1:ICACHE_TAG_LOW] :
                    ic_rw_addr[ICACHE_TAG_HIGH-1:ICACHE_TAG_LOW];

   ////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dbg_rd_way_ff <= '0;
      end else begin
         dbg_rd_way_ff <= dbg_rd_way;
      end
   end

   always_ff @(posedge clk) begin
      fetch_tag_ff <= ic_rw_addr[31:ICACHE_TAG_HIGH];   // Compared one cycle later
   end

   ////////////////////////////////////////////////////////////
   // Tag ways
   ////////////////////////////////////////////////////////////
   for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
      ic_sram #(
         .entry_t (ic_tag_entry_t),
         .DEPTH   (TAG_DEPTH)
      ) i_tag_sram (
         .clk  (clk),
         .we   (tag_we[i]),
         .re   (tag_re[i]),
         .addr (tag_idx),
         .d    (tag_wr_data),
         .q    (tag_q[i])
      );

      assign ic_rd_hit[i] = (tag_q[i].tag == fetch_tag_ff) & ic_tag_valid[i];
      assign way_perr[i]  = ^tag_q[i];   // XOR with the parity bit is 1 on an error
   end

   // Only valid ways can flag an error
   assign ic_tag_perr = |(way_perr & ic_tag_valid);

   always_comb begin
      ictag_debug_rd_data = '0;
      for (int i = 0; i < NUM_WAYS; i++) begin
         if (dbg_rd_way_ff[i]) begin
            ictag_debug_rd_data = ictag_debug_rd_data | tag_q[i];
         end
      end
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the instruction cache memory testbench with Verilator and run it.
# The exit status is the simulator's own: zero on pass, nonzero on $fatal.
cd "$(dirname "$0")" &&
   verilator --binary --timing -f sources.f --top-module tb_ic_mem -Mdir obj_dir &&
   ./obj_dir/Vtb_ic_mem ||
   exit 1

// ==== sources.f ====
+incdir+include
hw/ic_mem_pkg.sv
hw/ic_sram.sv
hw/ic_tag_array.sv
hw/ic_data_array.sv
hw/ic_mem.sv
test/tb_ic_mem.sv

// ==== include/ic_mem_vectors.svh ====
// Instruction cache memory stimulus table
// One operation per entry with the expected hit mask and tag parity error
`ifndef IC_MEM_VECTORS_SVH
`define IC_MEM_VECTORS_SVH

typedef enum logic [2:0] {
   FILL,
   READ,
   DBG_WR_TAG,
   DBG_RD_TAG,
   DBG_WR_DATA,
   DBG_RD_DATA
} ic_vec_op_e;

// Debug ops take addr[11:2] as the debug address
// DBG_WR_TAG writes addr[31:12] as the tag, with wrong parity when bad_par is set
// exp_hit and exp_perr apply to READ entries
typedef struct packed {
   ic_vec_op_e               op;
   logic [31:0]              addr;
   ic_mem_pkg::ic_way_mask_t way;
   ic_mem_pkg::ic_way_mask_t valid;
   logic                     bad_par;
   ic_mem_pkg::ic_way_mask_t exp_hit;
   logic                     exp_perr;
} ic_vec_t;

localparam int NUM_VECTORS = 22;

localparam ic_vec_t VECTORS [NUM_VECTORS] = '{
   '{FILL,        32'h1234_5140, 4'b0010, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{FILL,        32'h1234_5150, 4'b0010, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{FILL,        32'h1234_5160, 4'b0010, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{FILL,        32'h1234_5170, 4'b0010, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{READ,        32'h1234_5140, 4'b0000, 4'b0010, 1'b0, 4'b0010, 1'b0},
   '{READ,        32'h1234_5150, 4'b0000, 4'b0010, 1'b0, 4'b0010, 1'b0},
   '{READ,        32'h1234_5160, 4'b0000, 4'b0010, 1'b0, 4'b0010, 1'b0},
   '{READ,        32'h1234_5170, 4'b0000, 4'b0010, 1'b0, 4'b0010, 1'b0},
   '{READ,        32'hABCD_E140, 4'b0000, 4'b0010, 1'b0, 4'b0000, 1'b0},
   '{READ,        32'h1234_5140, 4'b0000, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{FILL,        32'h0BEE_F240, 4'b0100, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{READ,        32'h0BEE_F240, 4'b0000, 4'b0100, 1'b0, 4'b0000, 1'b0},
   '{DBG_WR_TAG,  32'h5A5A_5440, 4'b1000, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{DBG_RD_TAG,  32'h5A5A_5440, 4'b1000, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{READ,        32'h5A5A_5440, 4'b0000, 4'b1000, 1'b0, 4'b1000, 1'b0},
   '{DBG_WR_TAG,  32'h5A5A_5440, 4'b1000, 4'b0000, 1'b1, 4'b0000, 1'b0},
   '{DBG_RD_TAG,  32'h5A5A_5440, 4'b1000, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{READ,        32'h5A5A_5440, 4'b0000, 4'b1000, 1'b0, 4'b1000, 1'b1},
   '{READ,        32'h5A5A_5440, 4'b0000, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{DBG_WR_DATA, 32'h1234_5168, 4'b0010, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{DBG_RD_DATA, 32'h1234_5160, 4'b0010, 4'b0000, 1'b0, 4'b0000, 1'b0},
   '{READ,        32'h1234_5160, 4'b0000, 4'b0010, 1'b0, 4'b0010, 1'b0}
};

`endif

// ==== test/tb_ic_mem.sv ====
// Instruction cache memory testbench
// Table-driven fills, reads and debug accesses checked against a reference model
`timescale 1ns/1ps

module tb_ic_mem;

   import ic_mem_pkg::*;

   `include "ic_mem_vectors.svh"

   localparam int CLK_PERIOD = 4;
   localparam int CHK_W      = 136;   // Widest checked value, one row

   logic           clk;
   logic           rst_n;
   logic [31:4]    ic_rw_addr;
   logic           ic_rd_en;
   ic_way_mask_t   ic_wr_en;
   ic_row_t        ic_wr_data;
   ic_way_mask_t   ic_tag_valid;
   ic_debug_req_t  ic_debug;
   ic_way_mask_t   ic_rd_hit;
   logic           ic_tag_perr;
   ic_row_t        ic_rd_data;
   ic_tag_entry_t  ictag_debug_rd_data;

   logic [15:0]    lfsr_state;
   ic_tag_entry_t  tag_model [NUM_WAYS][TAG_DEPTH];
   ic_row_t        data_model [NUM_WAYS][DATA_DEPTH];

   ic_mem i_ic_mem (
      .clk                 (clk),
      .rst_n               (rst_n),
      .ic_rw_addr          (ic_rw_addr),
      .ic_rd_en            (ic_rd_en),
      .ic_wr_en            (ic_wr_en),
      .ic_wr_data          (ic_wr_data),
      .ic_tag_valid        (ic_tag_valid),
      .ic_debug            (ic_debug),
      .ic_rd_hit           (ic_rd_hit),
      .ic_tag_perr         (ic_tag_perr),
      .ic_rd_data          (ic_rd_data),
      .ictag_debug_rd_data (ictag_debug_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Random source and checking
   ////////////////////////////////////////////////////////////
   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic random_bits(input int n, output logic [CHK_W-1:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v[i]       = lfsr_state[0];   // One step per bit
      end
   endtask

   task automatic check_value(input string name, input logic [CHK_W-1:0] got,
                              input logic [CHK_W-1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("*** FAILED ***");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus and reference model
   ////////////////////////////////////////////////////////////
   task automatic drive_vector(input ic_vec_t v);
      logic [CHK_W-1:0] rnd;
      logic [33:0]      dbg_word;
      logic [TAG_W-1:0] tag;
      ic_debug_req_t    req;
      int               row;
      int               idx;
      tag = v.addr[31:12];
      row = int'(v.addr[11:4]);
      idx = int'(v.addr[11:6]);
      req = '0;
      req.way  = v.way;
      req.addr = v.addr[11:2];
      ic_rw_addr   <= v.addr[31:4];
      ic_tag_valid <= v.valid;   // Held through the check cycle
      case (v.op)
         FILL: begin
            random_bits(CHK_W, rnd);
            ic_wr_en   <= v.way;
            ic_wr_data <= rnd;
            for (int w = 0; w < NUM_WAYS; w++) begin
               if (v.way[w]) begin
                  data_model[w][row] = rnd;
                  if (v.addr[5:4] == 2'b11) begin
                     tag_model[w][idx] = {^tag, tag};   // Tag only with the last row
                  end
               end
            end
         end
         READ: ic_rd_en <= 1'b1;
         DBG_WR_TAG, DBG_WR_DATA: begin
            random_bits(34, rnd);
            dbg_word      = rnd[33:0];
            req.wr_en     = 1'b1;
            req.tag_array = (v.op == DBG_WR_TAG);
            if (v.op == DBG_WR_TAG) begin
               dbg_word[31:12] = tag;
               dbg_word[32]    = (^tag) ^ v.bad_par;
            end
            req.wr_data = dbg_word;
            for (int w = 0; w < NUM_WAYS; w++) begin
               if (v.way[w] && v.op == DBG_WR_TAG) begin
                  tag_model[w][idx] = {dbg_word[32], tag};
               end else if (v.way[w]) begin
                  data_model[w][row][v.addr[3:2]] = dbg_word;
               end
            end
            ic_debug <= req;
         end
         DBG_RD_TAG, DBG_RD_DATA: begin
            req.rd_en     = 1'b1;
            req.tag_array = (v.op == DBG_RD_TAG);
            ic_debug <= req;
         end
         default: ;
      endcase
   endtask

   task automatic release_strobes();
      ic_rd_en <= 1'b0;
      ic_wr_en <= '0;
      ic_debug <= '0;   // Address and valids stay put
   endtask

   task automatic check_vector(input ic_vec_t v);
      ic_row_t       exp_row;
      ic_tag_entry_t exp_tag;
      int            row;
      int            idx;
      row     = int'(v.addr[11:4]);
      idx     = int'(v.addr[11:6]);
      exp_row = '0;
      exp_tag = '0;
      case (v.op)
         READ: begin
            for (int w = 0; w < NUM_WAYS; w++) begin
               if (v.exp_hit[w]) exp_row = exp_row | data_model[w][row];
            end
            check_value("ic_rd_hit", CHK_W'(ic_rd_hit), CHK_W'(v.exp_hit));
            check_value("ic_tag_perr", CHK_W'(ic_tag_perr), CHK_W'(v.exp_perr));
            check_value("ic_rd_data", CHK_W'(ic_rd_data), CHK_W'(exp_row));
            // No debug tag read pending
            check_value("ictag_debug_rd_data", CHK_W'(ictag_debug_rd_data),
                        CHK_W'(exp_tag));
         end
         DBG_RD_TAG: begin
            for (int w = 0; w < NUM_WAYS; w++) begin
               if (v.way[w]) exp_tag = exp_tag | tag_model[w][idx];
            end
            check_value("ictag_debug_rd_data", CHK_W'(ictag_debug_rd_data),
                        CHK_W'(exp_tag));
         end
         DBG_RD_DATA: begin
            for (int w = 0; w < NUM_WAYS; w++) begin
               if (v.way[w]) exp_row = exp_row | data_model[w][row];
            end
            check_value("ic_rd_data", CHK_W'(ic_rd_data), CHK_W'(exp_row));
         end
         default: ;
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////
   initial begin
      rst_n        <= 1'b0;
      ic_rw_addr   <= '0;
      ic_rd_en     <= 1'b0;
      ic_wr_en     <= '0;
      ic_wr_data   <= '0;
      ic_tag_valid <= '0;
      ic_debug     <= '0;
      lfsr_state   = 16'd8029;
      for (int w = 0; w < NUM_WAYS; w++) begin
         for (int i = 0; i < TAG_DEPTH; i++) tag_model[w][i] = '0;
         for (int i = 0; i < DATA_DEPTH; i++) data_model[w][i] = '0;
      end
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      for (int n = 0; n < NUM_VECTORS; n++) begin
         @(posedge clk);
         drive_vector(VECTORS[n]);
         @(posedge clk);   // DUT samples the access here
         release_strobes();
         @(negedge clk);
         check_vector(VECTORS[n]);
      end
      $display("*** PASSED ***");
      $finish;
   end

   initial begin
      #(NUM_VECTORS * 4 * CLK_PERIOD + 100);
      $display("Timeout: the vector table did not finish in time");
      $display("*** FAILED ***");
      $fatal(1, "Watchdog expired");
   end

endmodule
